// File: common/iso14443a_rx_consts.svh
// timing constants for the iso 14443-a receive path, counted in clock cycles

`ifndef ISO14443A_RX_CONSTS_SVH
`define ISO14443A_RX_CONSTS_SVH

// ========================================
// bit timing
// ========================================

// clock cycles in one bit period of the demodulated field
`define RX_BIT_PERIOD 16

// cycles in half a bit period
// a pause that starts before this offset is a Z, one that starts at or after it is an X
`define RX_HALF_PERIOD 8

// ========================================
// framing
// ========================================

// consecutive Y symbols after which the sampler stops tracking bit periods
// and waits for the next falling edge of the pause signal
`define RX_IDLE_SYMBOLS 2

`endif

// File: common/iso14443a_rx_pkg.sv
// shared symbol, bit and event types of the iso 14443-a receive path

`default_nettype none

package iso14443a_rx_pkg;

    // ========================================
    // modified miller symbols
    // ========================================

    // X has a pause in the second half of the bit period, Z in the first half
    // and Y has none, more than one pause in a period is reported as an error
    typedef enum logic [1:0] {
        SYM_X   = 2'd0,
        SYM_Y   = 2'd1,
        SYM_Z   = 2'd2,
        SYM_ERR = 2'd3
    } miller_sym_e;

    // one symbol per bit period, sym only means something while valid is high
    typedef struct packed {
        logic        valid;
        miller_sym_e sym;
    } rx_symbol_t;

    // ========================================
    // decoded frame bits
    // ========================================

    // at most one of the four strobes is high in any cycle
    typedef struct packed {
        logic soc;
        logic eoc;
        logic error;
        logic bit_valid;
        logic value;
    } rx_bit_t;

    // byte level events, data_bits is 0 for a full byte
    // and gives the bit count of a partial byte delivered with eoc
    typedef struct packed {
        logic       soc;
        logic       eoc;
        logic       error;
        logic       data_valid;
        logic [7:0] data;
        logic [2:0] data_bits;
    } rx_event_t;

endpackage

`default_nettype wire

// File: verilog/miller_symbol_sampler.sv
// modified miller sampler, aligns to the first pause and classifies each bit period

`default_nettype none

`include "iso14443a_rx_consts.svh"

module miller_symbol_sampler (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         pause_n,
    output iso14443a_rx_pkg::rx_symbol_t symbol
);
    import iso14443a_rx_pkg::*;

    localparam int CNT_W = $clog2(`RX_BIT_PERIOD);
    localparam int RUN_W = $clog2(`RX_IDLE_SYMBOLS + 1);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`RX_BIT_PERIOD - 1);
    localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(`RX_HALF_PERIOD);
    localparam logic [RUN_W-1:0] IDLE_RUN = RUN_W'(`RX_IDLE_SYMBOLS);

    logic              in_frame;
    logic              pause_q;
    logic              pause_fall;
    logic [CNT_W-1:0]  cnt;
    logic [1:0]        pause_cnt;
    logic [1:0]        pause_cnt_next;
    logic              first_late;
    logic              late_next;
    logic [RUN_W-1:0]  y_run;
    miller_sym_e       sym_next;

    // pause_n is expected to be synchronous to clk already
    // a pause is counted once, on its falling edge
    assign pause_fall = pause_q & ~pause_n;

    // ========================================
    // per period pause bookkeeping
    // ========================================

    always_comb begin
        pause_cnt_next = pause_cnt;
        late_next      = first_late;
        if (pause_fall) begin
            // only the first pause of a period decides between X and Z
            if (pause_cnt == 2'd0) begin
                late_next = (cnt >= HALF_CNT);
            end
            // saturate at two, anything above one pause is an error anyway
            if (pause_cnt != 2'd2) begin
                pause_cnt_next = pause_cnt + 2'd1;
            end
        end

        // classification including a pause that starts in the last cycle
        case (pause_cnt_next)
            2'd0:    sym_next = SYM_Y;
            2'd1:    sym_next = late_next ? SYM_X : SYM_Z;
            default: sym_next = SYM_ERR;
        endcase
    end

    // ========================================
    // framing and symbol output
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_frame   <= 1'b0;
            pause_q    <= 1'b1;
            cnt        <= '0;
            pause_cnt  <= 2'd0;
            first_late <= 1'b0;
            y_run      <= '0;
            symbol     <= '0;
        end else begin
            pause_q      <= pause_n;
            symbol.valid <= 1'b0;

            if (!in_frame) begin
                // the first pause defines offset 0 of the bit grid
                if (pause_fall) begin
                    in_frame   <= 1'b1;
                    cnt        <= CNT_W'(1);
                    pause_cnt  <= 2'd1;
                    first_late <= 1'b0;
                    y_run      <= '0;
                end
            end else if (cnt == LAST_CNT) begin
                symbol.valid <= 1'b1;
                symbol.sym   <= sym_next;
                cnt          <= '0;
                pause_cnt    <= 2'd0;
                first_late   <= 1'b0;

                if (sym_next == SYM_ERR) begin
                    // the grid can no longer be trusted, wait for a fresh pause
                    in_frame <= 1'b0;
                    y_run    <= '0;
                end else if (sym_next == SYM_Y) begin
                    if (y_run == IDLE_RUN - RUN_W'(1)) begin
                        in_frame <= 1'b0;
                        y_run    <= '0;
                    end else begin
                        y_run <= y_run + RUN_W'(1);
                    end
                end else begin
                    y_run <= '0;
                end
            end else begin
                cnt        <= cnt + CNT_W'(1);
                pause_cnt  <= pause_cnt_next;
                first_late <= late_next;
            end
        end
    end

endmodule

`default_nettype wire

// File: rx_frame/miller_frame_decode.sv
// modified miller frame decoder, turns symbols into soc, data bits, eoc and error

`default_nettype none

module miller_frame_decode (
    input  logic                         clk,
    input  logic                         rst_n,
    input  iso14443a_rx_pkg::rx_symbol_t symbol,
    output iso14443a_rx_pkg::rx_bit_t    rx_bit
);
    import iso14443a_rx_pkg::*;

    logic    active;
    logic    active_next;
    logic    prev_bit;
    logic    prev_next;
    rx_bit_t bit_next;

    // ========================================
    // sequence rules
    // ========================================

    always_comb begin
        bit_next    = '0;
        active_next = active;
        prev_next   = prev_bit;

        if (symbol.valid) begin
            if (!active) begin
                // only a Z can open a frame, other symbols on an idle line are noise
                if (symbol.sym == SYM_Z) begin
                    bit_next.soc = 1'b1;
                    active_next  = 1'b1;
                    // start of frame acts as a logical 0 for the next symbol
                    prev_next    = 1'b0;
                end
            end else begin
                case (symbol.sym)
                    SYM_X: begin
                        bit_next.bit_valid = 1'b1;
                        bit_next.value     = 1'b1;
                        prev_next          = 1'b1;
                    end
                    SYM_Y: begin
                        if (prev_bit) begin
                            // a 0 following a 1 is sent without a pause
                            bit_next.bit_valid = 1'b1;
                            bit_next.value     = 1'b0;
                            prev_next          = 1'b0;
                        end else begin
                            // logical 0 then no pause marks the end of the frame
                            bit_next.eoc = 1'b1;
                            active_next  = 1'b0;
                        end
                    end
                    SYM_Z: begin
                        if (!prev_bit) begin
                            bit_next.bit_valid = 1'b1;
                            bit_next.value     = 1'b0;
                        end else begin
                            // Z may never follow a 1
                            bit_next.error = 1'b1;
                            active_next    = 1'b0;
                        end
                    end
                    default: begin
                        bit_next.error = 1'b1;
                        active_next    = 1'b0;
                    end
                endcase
            end
        end
    end

    // ========================================
    // state and output registers
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            prev_bit <= 1'b0;
            rx_bit   <= '0;
        end else begin
            active   <= active_next;
            prev_bit <= prev_next;
            rx_bit   <= bit_next;
        end
    end

endmodule

`default_nettype wire

// File: rx_frame/rx_byte_assembler.sv
// byte assembler, packs frame bits LSB first, checks odd parity and emits rx events

`default_nettype none

module rx_byte_assembler (
    input  logic                        clk,
    input  logic                        rst_n,
    input  iso14443a_rx_pkg::rx_bit_t   rx_bit,
    output iso14443a_rx_pkg::rx_event_t rx_event
);
    import iso14443a_rx_pkg::*;

    logic [7:0] shift;
    logic [7:0] shift_next;
    logic [3:0] count;
    logic [3:0] count_next;
    logic       par;
    logic       par_next;
    logic       skip;
    logic       skip_next;
    rx_event_t  ev_next;

    // ========================================
    // event decision
    // ========================================

    always_comb begin
        ev_next    = '0;
        shift_next = shift;
        count_next = count;
        par_next   = par;
        skip_next  = skip;

        if (rx_bit.soc) begin
            ev_next.soc = 1'b1;
            count_next  = 4'd0;
            skip_next   = 1'b0;
        end else if (rx_bit.error) begin
            // a decoder error ends the frame, no eoc will follow
            ev_next.error = 1'b1;
            count_next    = 4'd0;
            skip_next     = 1'b0;
        end else if (rx_bit.eoc) begin
            ev_next.eoc = 1'b1;
            // after a parity error the frame has already been flagged
            if (!skip) begin
                if (count == 4'd8) begin
                    // eight data bits but the parity bit never came
                    ev_next.error = 1'b1;
                end else if (count != 4'd0) begin
                    // short frame, the partial byte rides on the eoc event
                    ev_next.data_valid = 1'b1;
                    ev_next.data_bits  = count[2:0];
                    ev_next.data       = shift;
                end
            end
            count_next = 4'd0;
            skip_next  = 1'b0;
        end else if (rx_bit.bit_valid && !skip) begin
            if (count == 4'd8) begin
                // ninth bit is the parity bit, data ones plus parity must be odd
                if (par ^ rx_bit.value) begin
                    ev_next.data_valid = 1'b1;
                    ev_next.data       = shift;
                end else begin
                    ev_next.error = 1'b1;
                    skip_next     = 1'b1;
                end
                count_next = 4'd0;
            end else begin
                if (count == 4'd0) begin
                    // first bit of a byte also clears the bits not yet received
                    shift_next = {7'b0, rx_bit.value};
                    par_next   = rx_bit.value;
                end else begin
                    shift_next[count[2:0]] = rx_bit.value;
                    par_next               = par ^ rx_bit.value;
                end
                count_next = count + 4'd1;
            end
        end
    end

    // ========================================
    // registers
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count    <= 4'd0;
            skip     <= 1'b0;
            rx_event <= '0;
        end else begin
            count    <= count_next;
            skip     <= skip_next;
            rx_event <= ev_next;
        end
    end

    // byte shift register and running parity
    always_ff @(posedge clk) begin
        shift <= shift_next;
        par   <= par_next;
    end

endmodule

`default_nettype wire

// File: verilog/iso14443a_rx_top.sv
// iso 14443-a card receive path, from the sampled pause signal to byte events

`default_nettype none

module iso14443a_rx_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pause_n,
    output iso14443a_rx_pkg::rx_event_t rx_event
);
    import iso14443a_rx_pkg::*;

    // one symbol per bit period from the sampler
    rx_symbol_t symbol;

    // decoded frame bits, one cycle after each symbol
    rx_bit_t    rx_bit;

    // ========================================
    // receive chain
    // ========================================

    miller_symbol_sampler u_sampler (
        .clk     (clk),
        .rst_n   (rst_n),
        .pause_n (pause_n),
        .symbol  (symbol)
    );

    miller_frame_decode u_frame_decode (
        .clk    (clk),
        .rst_n  (rst_n),
        .symbol (symbol),
        .rx_bit (rx_bit)
    );

    // events appear two cycles after the symbol that caused them
    rx_byte_assembler u_byte_assembler (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_bit   (rx_bit),
        .rx_event (rx_event)
    );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
// testbench clock and reset source, 10 ns clock with reset held low for 10 cycles

`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset leaves on a rising edge, like any other driven input
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/rx_event_sink.sv
// expected event queue, compares every flagged DUT event with the next expected one

`default_nettype none

module rx_event_sink (
    input wire                          clk,
    input wire                          rst_n,
    input iso14443a_rx_pkg::rx_event_t rx_event,
    output bit                          check_failed
);
    timeunit 1ns;
    timeprecision 1ps;

    import iso14443a_rx_pkg::*;

    rx_event_t exp_q[$];
    string     name_q[$];

    // queue one expected event together with the name of its test
    task automatic push_expected(input rx_event_t ev, input string name);
        exp_q.push_back(ev);
        name_q.push_back(name);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    // data only counts when the event carries data, otherwise it is a don't care
    function automatic bit event_match(input rx_event_t exp_ev, input rx_event_t act_ev);
        bit same;
        same = (exp_ev.soc == act_ev.soc) && (exp_ev.eoc == act_ev.eoc)
            && (exp_ev.error == act_ev.error) && (exp_ev.data_valid == act_ev.data_valid)
            && (exp_ev.data_bits == act_ev.data_bits);
        if (exp_ev.data_valid && (exp_ev.data != act_ev.data)) begin
            same = 1'b0;
        end
        return same;
    endfunction

    // ========================================
    // compare on the falling edge
    // ========================================

    // the DUT output is registered, so it is stable half a cycle after the rising edge
    always @(negedge clk) begin
        rx_event_t exp_ev;
        string     name;
        if (rst_n && (rx_event.soc || rx_event.eoc || rx_event.error || rx_event.data_valid)) begin
            if (exp_q.size() == 0) begin
                $display("DUT produced event %h while no event was expected", rx_event);
                check_failed = 1'b1;
            end else begin
                exp_ev = exp_q.pop_front();
                name   = name_q.pop_front();
                assert (event_match(exp_ev, rx_event)) else begin
                    $display("Error %s expected %h actual %h", name, exp_ev, rx_event);
                    check_failed = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/iso14443a_rx_tb.sv
// testbench for the iso 14443-a receive path, encodes a frame table into pause waveforms

`default_nettype none

`include "iso14443a_rx_consts.svh"

module iso14443a_rx_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import iso14443a_rx_pkg::*;

    localparam int NROWS = 10;

    logic      clk;
    logic      rst_n;
    logic      pause_n;
    rx_event_t rx_event;
    bit        check_failed;

    // in the frame table violation 1 is a Z after a 1 and violation 2 is two pauses in one period
    string      t_name[NROWS];
    int         t_nbytes[NROWS];
    logic [7:0] t_bytes[NROWS][5];
    int         t_trail[NROWS];
    bit         t_corrupt[NROWS];
    int         t_viol[NROWS];

    // symbols of the current frame use the package enum
    miller_sym_e sym_q[$];

    tb_clock_gen clock_gen (.clk(clk), .rst_n(rst_n));

    iso14443a_rx_top uut (.clk(clk), .rst_n(rst_n), .pause_n(pause_n), .rx_event(rx_event));

    rx_event_sink sink (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_event     (rx_event),
        .check_failed (check_failed)
    );

    task automatic set_row(input int r, input string n, input int nb, input logic [39:0] b,
                           input int tr, input bit cor, input int v);
        t_name[r]    = n;
        t_nbytes[r]  = nb;
        t_trail[r]   = tr;
        t_corrupt[r] = cor;
        t_viol[r]    = v;
        for (int i = 0; i < 5; i++) begin
            t_bytes[r][i] = b[8*i +: 8];
        end
    endtask

    // soc plus nine periods per byte, trailing bits, violation, end and the idle gap
    function automatic int row_periods(input int r);
        return 1 + 9 * t_nbytes[r] + t_trail[r] + 4 + `RX_BIT_PERIOD;
    endfunction

    // ========================================
    // symbol encoder
    // ========================================

    task automatic push_bit(input bit b, inout bit prev);
        // a 0 after a 1 carries no pause, any other 0 is a Z
        sym_q.push_back(b ? SYM_X : (prev ? SYM_Y : SYM_Z));
        prev = b;
    endtask

    task automatic build_symbols(input int r);
        bit         prev;
        logic [7:0] b;
        prev = 1'b0;
        sym_q.delete();
        sym_q.push_back(SYM_Z);
        for (int i = 0; i < t_nbytes[r]; i++) begin
            b = t_bytes[r][i];
            for (int k = 0; k < 8; k++) begin
                push_bit(b[k], prev);
            end
            // odd parity follows each byte and the first one is corrupted on request
            push_bit(~^b ^ (t_corrupt[r] && i == 0), prev);
        end
        for (int k = 0; k < t_trail[r]; k++) begin
            push_bit(t_bytes[r][t_nbytes[r]][k], prev);
        end
        if (t_viol[r] == 1) begin
            push_bit(1'b1, prev);
            sym_q.push_back(SYM_Z);
        end else if (t_viol[r] == 2) begin
            sym_q.push_back(SYM_ERR);
        end else begin
            // a final 0 already serves as the logical 0 before the closing Y
            if (prev) begin
                push_bit(1'b0, prev);
            end
            sym_q.push_back(SYM_Y);
        end
    endtask

    // ========================================
    // expected events from the sequence and byte rules
    // ========================================

    task automatic build_expected(input int r);
        bit         active;
        bit         prev;
        bit         skip;
        bit         par;
        int         count;
        logic [7:0] acc;
        rx_event_t  ev;
        active = 1'b0;
        prev   = 1'b0;
        skip   = 1'b0;
        par    = 1'b0;
        count  = 0;
        acc    = '0;
        foreach (sym_q[i]) begin
            ev = '0;
            if (!active) begin
                if (sym_q[i] == SYM_Z) begin
                    ev.soc = 1'b1;
                    active = 1'b1;
                    prev   = 1'b0;
                    count  = 0;
                    skip   = 1'b0;
                end
            end else if (sym_q[i] == SYM_ERR || (sym_q[i] == SYM_Z && prev)) begin
                ev.error = 1'b1;
                active   = 1'b0;
            end else if (sym_q[i] == SYM_Y && !prev) begin
                ev.eoc = 1'b1;
                active = 1'b0;
                if (!skip && count == 8) begin
                    ev.error = 1'b1;
                end else if (!skip && count != 0) begin
                    ev.data_valid = 1'b1;
                    ev.data_bits  = 3'(count);
                    ev.data       = acc;
                end
            end else begin
                // this is a data bit where X is a 1 and the remaining cases are a 0
                prev = (sym_q[i] == SYM_X);
                if (!skip && count == 8) begin
                    if ((^acc) ^ prev) begin
                        ev.data_valid = 1'b1;
                        ev.data       = acc;
                    end else begin
                        ev.error = 1'b1;
                        skip     = 1'b1;
                    end
                    count = 0;
                end else if (!skip) begin
                    if (count == 0) begin
                        acc = '0;
                    end
                    acc[count] = prev;
                    count++;
                end
            end
            if (ev.soc || ev.eoc || ev.error || ev.data_valid) begin
                sink.push_expected(ev, t_name[r]);
            end
        end
    endtask

    // ========================================
    // pause waveform driver
    // ========================================

    task automatic drive_symbols();
        bit low;
        foreach (sym_q[i]) begin
            for (int c = 0; c < `RX_BIT_PERIOD; c++) begin
                low = ((sym_q[i] == SYM_Z || sym_q[i] == SYM_ERR) && c < 3)
                    || ((sym_q[i] == SYM_X || sym_q[i] == SYM_ERR)
                        && c >= `RX_HALF_PERIOD && c < `RX_HALF_PERIOD + 3);
                @(posedge clk);
                pause_n <= ~low;
            end
        end
        // idle gap between frames
        repeat (`RX_BIT_PERIOD * `RX_BIT_PERIOD) @(posedge clk);
        pause_n <= 1'b1;
    endtask

    initial begin
        pause_n = 1'b1;
        set_row(0, "one_byte_a5", 1, 40'ha5, 0, 1'b0, 0);
        set_row(1, "two_bytes_00_ff", 2, 40'hff_00, 0, 1'b0, 0);
        set_row(2, "three_bytes_alt", 3, 40'h0f_aa_55, 0, 1'b0, 0);
        set_row(3, "four_bytes", 4, 40'h78_56_34_12, 0, 1'b0, 0);
        set_row(4, "short_frame_26", 0, 40'h26, 7, 1'b0, 0);
        set_row(5, "parity_error", 3, 40'h33_22_11, 0, 1'b1, 0);
        set_row(6, "missing_parity", 0, 40'h43, 8, 1'b0, 0);
        set_row(7, "z_after_one", 1, 40'h5a, 0, 1'b0, 1);
        set_row(8, "double_pause", 1, 40'h3c, 0, 1'b0, 2);
        set_row(9, "after_violation", 1, 40'h9e, 0, 1'b0, 0);

        @(posedge rst_n);
        repeat (20) @(posedge clk);
        for (int r = 0; r < NROWS; r++) begin
            build_symbols(r);
            build_expected(r);
            drive_symbols();
        end
        while (sink.pending() != 0) begin
            @(posedge clk);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

    // a failed event check in the sink ends the run at once
    initial begin
        wait (check_failed);
        $display("TESTBENCH FAILED");
        $fatal(1, "event check failed");
    end

    // the watchdog allows twice the summed bit periods of the whole table
    initial begin
        longint limit;
        #1;
        limit = 0;
        for (int r = 0; r < NROWS; r++) begin
            limit += row_periods(r);
        end
        limit = limit * `RX_BIT_PERIOD * 10 * 2 + 1000;
        #(limit);
        $display("timeout, expected events still pending");
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: iso14443a_rx_top.f
+incdir+common
common/iso14443a_rx_pkg.sv
verilog/miller_symbol_sampler.sv
rx_frame/miller_frame_decode.sv
rx_frame/rx_byte_assembler.sv
verilog/iso14443a_rx_top.sv
tb/tb_clock_gen.sv
tb/rx_event_sink.sv
tb/iso14443a_rx_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the iso 14443-a receive testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wall \
    --top-module iso14443a_rx_tb \
    -f iso14443a_rx_top.f \
    -o sim_iso14443a_rx \
    && ./obj_dir/sim_iso14443a_rx \
    && echo "simulation finished" \
    || { echo "simulation failed"; exit 1; }
